// ==== rtl/centi_video_pkg.sv ====
`default_nettype none

package centi_video_pkg;

   // horizontal timing in pixels, one pixel is two clocks
   localparam int H_TOTAL     = 384;
   localparam int H_ACTIVE    = 256;
   localparam int HSYNC_START = 288;
   localparam int HSYNC_END   = 320;

   // vertical timing in lines, stands in for the vertical PROM
   localparam int V_TOTAL     = 256;
   localparam int V_ACTIVE    = 240;
   localparam int VSYNC_START = 244;
   localparam int VSYNC_END   = 248;

   localparam int H_POS_W     = 9;
   localparam int V_POS_W     = 8;
   localparam int CRAM_ADDR_W = 5;
   localparam int CRAM_DEPTH  = 32;
   localparam int COLOR_W     = 8;
   localparam int RGB_W       = 9;

   // centipede colour, active low channels with a shared intensity bit
   typedef struct packed {
      logic [3:0] pad;
      logic       intensity;
      logic       red_n;
      logic       green_n;
      logic       blue_n;
   } centi_color_t;

   // millipede colour, direct bgr with two bits of green
   typedef struct packed {
      logic [2:0] blue;
      logic [1:0] green;
      logic [2:0] red;
   } milli_color_t;

   // one colour ram word, read through either view
   typedef union packed {
      centi_color_t centi;
      milli_color_t milli;
   } color_word_t;

endpackage

`default_nettype wire

// ==== rtl/video_timing_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface video_timing_if
   import centi_video_pkg::*;
();

   logic               pix_en;
   logic [H_POS_W-1:0] h_pos;
   logic [V_POS_W-1:0] v_pos;
   logic               hblank;
   logic               vblank;
   logic               hsync;
   logic               vsync;

   // sync generator side
   modport source (output pix_en, h_pos, v_pos, hblank, vblank, hsync, vsync);

   // colour ram and palette side
   modport sink (input pix_en, h_pos, v_pos, hblank, vblank, hsync, vsync);

endinterface

`default_nettype wire

// ==== rtl/video_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_timing
   import centi_video_pkg::*;
(
   input  logic          s_12mhz,
   input  logic          hs_set,
   video_timing_if.source tim
);

   logic               pix_en;
   logic [H_POS_W-1:0] h_pos;
   logic [H_POS_W-1:0] h_next;
   logic [V_POS_W-1:0] v_pos;
   logic [V_POS_W-1:0] v_next;
   logic               line_end;
   logic               hblank;
   logic               vblank;
   logic               hsync;
   logic               vsync;

   // pixel strobe, 6 MHz enable from the 12 MHz clock
   always_ff @(posedge s_12mhz or posedge hs_set) begin
      if (hs_set) begin
         pix_en <= 1'b0;
      end else begin
         pix_en <= ~pix_en;
      end
   end

   // next counter values, so the decodes line up with the counters
   always_comb begin
      line_end = (h_pos == H_POS_W'(H_TOTAL - 1));
      h_next   = line_end ? '0 : h_pos + 1'b1;
      if (!line_end) begin
         v_next = v_pos;
      end else if (v_pos == V_POS_W'(V_TOTAL - 1)) begin
         v_next = '0;
      end else begin
         v_next = v_pos + 1'b1;
      end
   end

   always_ff @(posedge s_12mhz or posedge hs_set) begin
      if (hs_set) begin
         h_pos <= '0;
         v_pos <= '0;
      end else if (pix_en) begin
         h_pos <= h_next;
         v_pos <= v_next;
      end
   end

   // blanking and sync windows, registered with the counters
   always_ff @(posedge s_12mhz or posedge hs_set) begin
      if (hs_set) begin
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b0;
         vsync  <= 1'b0;
      end else if (pix_en) begin
         hblank <= (h_next >= H_POS_W'(H_ACTIVE));
         vblank <= (v_next >= V_POS_W'(V_ACTIVE));
         hsync  <= (h_next >= H_POS_W'(HSYNC_START)) &&
                   (h_next <  H_POS_W'(HSYNC_END));
         // vertical sync sits inside the blanked lines
         vsync  <= (v_next >= V_POS_W'(VSYNC_START)) &&
                   (v_next <  V_POS_W'(VSYNC_END));
      end
   end

   assign tim.pix_en = pix_en;
   assign tim.h_pos  = h_pos;
   assign tim.v_pos  = v_pos;
   assign tim.hblank = hblank;
   assign tim.vblank = vblank;
   assign tim.hsync  = hsync;
   assign tim.vsync  = vsync;

endmodule

`default_nettype wire

// ==== rtl/color_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module color_ram
   import centi_video_pkg::*;
(
   input  logic                   s_12mhz,
   input  logic                   milli_i,
   input  logic                   cram_wr_i,
   input  logic [CRAM_ADDR_W-1:0] cram_addr_i,
   input  logic [COLOR_W-1:0]     cram_data_i,
   input  logic [CRAM_ADDR_W-1:0] pix_index_i,
   video_timing_if.sink           tim,
   output color_word_t            color_o
);

   color_word_t            mem [0:CRAM_DEPTH-1];
   logic [CRAM_ADDR_W-1:0] wr_addr;
   logic [COLOR_W-1:0]     wr_data;
   logic [CRAM_ADDR_W-1:0] pix_addr;
   logic [CRAM_ADDR_W-1:0] rd_addr;

   // centipede only decodes 16 entries and a 4 bit data bus
   always_comb begin
      if (milli_i) begin
         wr_addr  = cram_addr_i;
         wr_data  = cram_data_i;
         pix_addr = pix_index_i;
      end else begin
         wr_addr  = {1'b0, cram_addr_i[CRAM_ADDR_W-2:0]};
         wr_data  = {2{cram_data_i[3:0]}};
         pix_addr = {1'b0, pix_index_i[CRAM_ADDR_W-2:0]};
      end
   end

   // host port
   always_ff @(posedge s_12mhz) begin
      if (cram_wr_i) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // pixel address is taken once per pixel
   always_ff @(posedge s_12mhz) begin
      if (tim.pix_en) begin
         rd_addr <= pix_addr;
      end
   end

   // registered lookup, settles before the next pixel strobe
   always_ff @(posedge s_12mhz) begin
      color_o <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== rtl/palette_encoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module palette_encoder
   import centi_video_pkg::*;
(
   input  logic             s_12mhz,
   input  logic             hs_set,
   input  logic             milli_i,
   input  color_word_t      color_i,
   video_timing_if.sink     tim,
   output logic [RGB_W-1:0] rgb_o,
   output logic             hsync_o,
   output logic             vsync_o,
   output logic             hblank_o,
   output logic             vblank_o,
   output logic             sync_o
);

   logic [RGB_W-1:0] centi_rgb;
   logic [RGB_W-1:0] milli_rgb;
   logic [RGB_W-1:0] rgb_next;

   // one centipede gun, full on when its bit is low
   function automatic logic [2:0] centi_chan(input logic bit_n, input logic intensity);
      if (!bit_n) begin
         return 3'b111;
      end
      return intensity ? 3'b000 : 3'b011;
   endfunction

   always_comb begin
      centi_rgb = {centi_chan(color_i.centi.red_n,   color_i.centi.intensity),
                   centi_chan(color_i.centi.green_n, color_i.centi.intensity),
                   centi_chan(color_i.centi.blue_n,  color_i.centi.intensity)};
      // green gets a fixed low bit to fill three bits
      milli_rgb = ~{color_i.milli.red, color_i.milli.green, 1'b1, color_i.milli.blue};
      rgb_next  = milli_i ? milli_rgb : centi_rgb;
   end

   always_ff @(posedge s_12mhz or posedge hs_set) begin
      if (hs_set) begin
         rgb_o <= '0;
      end else if (tim.pix_en) begin
         rgb_o <= rgb_next;
      end
   end

   assign hsync_o  = tim.hsync;
   assign vsync_o  = tim.vsync;
   assign hblank_o = tim.hblank;
   assign vblank_o = tim.vblank;

   // composite sync, high outside both sync pulses
   assign sync_o = ~(tim.hsync | tim.vsync);

endmodule

`default_nettype wire

// ==== rtl/centi_video_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module centi_video_top
   import centi_video_pkg::*;
(
   input  logic                   s_12mhz,
   input  logic                   hs_set,
   input  logic                   milli_i,
   input  logic                   cram_wr_i,
   input  logic [CRAM_ADDR_W-1:0] cram_addr_i,
   input  logic [COLOR_W-1:0]     cram_data_i,
   input  logic [CRAM_ADDR_W-1:0] pix_index_i,
   output logic [RGB_W-1:0]       rgb_o,
   output logic                   hsync_o,
   output logic                   vsync_o,
   output logic                   hblank_o,
   output logic                   vblank_o,
   output logic                   sync_o,
   output logic                   pix_en_o
);

   video_timing_if tim_if ();

   color_word_t color_word;

   video_timing video_timing_inst (
      .s_12mhz (s_12mhz),
      .hs_set  (hs_set),
      .tim     (tim_if.source)
   );

   color_ram color_ram_inst (
      .s_12mhz     (s_12mhz),
      .milli_i     (milli_i),
      .cram_wr_i   (cram_wr_i),
      .cram_addr_i (cram_addr_i),
      .cram_data_i (cram_data_i),
      .pix_index_i (pix_index_i),
      .tim         (tim_if.sink),
      .color_o     (color_word)
   );

   palette_encoder palette_encoder_inst (
      .s_12mhz  (s_12mhz),
      .hs_set   (hs_set),
      .milli_i  (milli_i),
      .color_i  (color_word),
      .tim      (tim_if.sink),
      .rgb_o    (rgb_o),
      .hsync_o  (hsync_o),
      .vsync_o  (vsync_o),
      .hblank_o (hblank_o),
      .vblank_o (vblank_o),
      .sync_o   (sync_o)
   );

   // pixel strobe brought out for the host side
   assign pix_en_o = tim_if.pix_en;

endmodule

`default_nettype wire

// ==== sim/centi_video_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_timing_props
   import centi_video_pkg::*;
(
   input logic               s_12mhz,
   input logic               hs_set,
   input logic               pix_en,
   input logic [H_POS_W-1:0] h_pos,
   input logic               hblank,
   input logic               vblank,
   input logic               hsync,
   input logic               vsync
);

   hsync_in_hblank: assert property (@(posedge s_12mhz) disable iff (hs_set)
      hsync |-> hblank)
      else $error("hsync high outside horizontal blanking");

   vsync_in_vblank: assert property (@(posedge s_12mhz) disable iff (hs_set)
      vsync |-> vblank)
      else $error("vsync high outside vertical blanking");

   // first edge after reset has no previous strobe to compare with
   pix_en_toggles: assert property (@(posedge s_12mhz) disable iff (hs_set)
      !$past(hs_set) |-> (pix_en != $past(pix_en)))
      else $error("pixel strobe did not alternate");

   h_pos_in_range: assert property (@(posedge s_12mhz) disable iff (hs_set)
      h_pos < H_POS_W'(H_TOTAL))
      else $error("horizontal position past end of line");

endmodule

bind video_timing video_timing_props video_timing_props_inst (
   .s_12mhz (s_12mhz),
   .hs_set  (hs_set),
   .pix_en  (pix_en),
   .h_pos   (h_pos),
   .hblank  (hblank),
   .vblank  (vblank),
   .hsync   (hsync),
   .vsync   (vsync)
);

`default_nettype wire

// ==== sim/centi_video_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module centi_video_tb
   import centi_video_pkg::*;
();

   logic                   s_12mhz;
   logic                   hs_set;
   logic                   milli_i;
   logic                   cram_wr_i;
   logic [CRAM_ADDR_W-1:0] cram_addr_i;
   logic [COLOR_W-1:0]     cram_data_i;
   logic [CRAM_ADDR_W-1:0] pix_index_i;
   logic [RGB_W-1:0]       rgb_o;
   logic                   hsync_o;
   logic                   vsync_o;
   logic                   hblank_o;
   logic                   vblank_o;
   logic                   sync_o;
   logic                   pix_en_o;

   // reference copy of the colour ram
   color_word_t model_mem [0:CRAM_DEPTH-1];
   logic [31:0] lfsr_state;
   int          line_total;
   int          sync_high;
   int          blank_high;

   centi_video_top centi_video_top_inst (
      .s_12mhz     (s_12mhz),
      .hs_set      (hs_set),
      .milli_i     (milli_i),
      .cram_wr_i   (cram_wr_i),
      .cram_addr_i (cram_addr_i),
      .cram_data_i (cram_data_i),
      .pix_index_i (pix_index_i),
      .rgb_o       (rgb_o),
      .hsync_o     (hsync_o),
      .vsync_o     (vsync_o),
      .hblank_o    (hblank_o),
      .vblank_o    (vblank_o),
      .sync_o      (sync_o),
      .pix_en_o    (pix_en_o)
   );

   initial begin
      s_12mhz = 1'b0;
      forever #50 s_12mhz = ~s_12mhz;
   end

   task automatic report_mismatch(input string test, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("ERROR %s: expected 0x%0h actual 0x%0h", test, exp, act);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
   endtask

   task automatic wait_failed(input string what);
      $display("TIMEOUT: %s", what);
      $display(">>> FAIL");
      $fatal(1, "wait timed out");
   endtask

   task automatic check_value(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act == exp) else report_mismatch(test, exp, act);
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
   endtask

   // one clock, inputs are driven right after this returns
   task automatic tick();
      @(posedge s_12mhz);
      #10;
      check_value("composite_sync", (hsync_o || vsync_o) ? 32'd0 : 32'd1, 32'(sync_o));
   endtask

   function automatic logic [2:0] gun_level(input logic bit_n, input logic inten);
      if (bit_n == 1'b0) begin
         return 3'b111;
      end else if (inten) begin
         return 3'b000;
      end
      return 3'b011;
   endfunction

   function automatic logic [RGB_W-1:0] expected_rgb(input logic [4:0] idx,
                                                     input logic milli);
      logic [4:0]  addr;
      color_word_t w;
      addr = milli ? idx : {1'b0, idx[3:0]};
      w    = model_mem[addr];
      if (milli) begin
         return ~{w.milli.red, w.milli.green, 1'b1, w.milli.blue};
      end
      return {gun_level(w.centi.red_n, w.centi.intensity),
              gun_level(w.centi.green_n, w.centi.intensity),
              gun_level(w.centi.blue_n, w.centi.intensity)};
   endfunction

   task automatic host_write(input logic [4:0] addr, input logic [7:0] data);
      cram_wr_i   = 1'b1;
      cram_addr_i = addr;
      cram_data_i = data;
      // centipede keeps 16 entries of one nibble each
      if (milli_i) begin
         model_mem[addr] = data;
      end else begin
         model_mem[{1'b0, addr[3:0]}] = {data[3:0], data[3:0]};
      end
      tick();
      cram_wr_i = 1'b0;
   endtask

   task automatic check_reset_state(input string test);
      check_value({test, " rgb_o"}, 32'd0, 32'(rgb_o));
      check_value({test, " hsync_o"}, 32'd0, 32'(hsync_o));
      check_value({test, " vsync_o"}, 32'd0, 32'(vsync_o));
      check_value({test, " hblank_o"}, 32'd0, 32'(hblank_o));
      check_value({test, " vblank_o"}, 32'd0, 32'(vblank_o));
      check_value({test, " pix_en_o"}, 32'd0, 32'(pix_en_o));
      check_value({test, " sync_o"}, 32'd1, 32'(sync_o));
   endtask

   task automatic wait_pix_high();
      int n;
      n = 0;
      while (pix_en_o !== 1'b1) begin
         if (n >= 4) begin
            wait_failed("pix_en_o never went high");
         end
         tick();
         n++;
      end
   endtask

   function automatic logic selected_sync(input logic vertical);
      return vertical ? vsync_o : hsync_o;
   endfunction

   function automatic logic selected_blank(input logic vertical);
      return vertical ? vblank_o : hblank_o;
   endfunction

   // clocks from one sync rise to the next, with pulse and blank widths
   task automatic measure_period(input logic vertical, output int total,
                                 output int sync_hi, output int blank_hi);
      int   limit;
      int   guard;
      logic prev_sync;
      limit     = vertical ? V_TOTAL * H_TOTAL * 2 + 1000 : H_TOTAL * 2 + 1000;
      guard     = 0;
      prev_sync = 1'b1;
      while (!(prev_sync == 1'b0 && selected_sync(vertical) == 1'b1)) begin
         if (guard >= limit) begin
            wait_failed(vertical ? "vsync_o never rose" : "hsync_o never rose");
         end
         prev_sync = selected_sync(vertical);
         tick();
         guard++;
      end
      total    = 0;
      sync_hi  = 0;
      blank_hi = 0;
      do begin
         if (selected_sync(vertical)) sync_hi++;
         if (selected_blank(vertical)) blank_hi++;
         total++;
         prev_sync = selected_sync(vertical);
         tick();
         if (total >= limit) begin
            wait_failed(vertical ? "vsync_o did not rise again" : "hsync_o did not rise again");
         end
      end while (!(prev_sync == 1'b0 && selected_sync(vertical) == 1'b1));
   endtask

   // one index per pixel, rgb_o lags the sampled index by one pixel
   task automatic run_pixels(input string test, input int count, input logic sequential);
      logic [4:0]  idx;
      logic [4:0]  prev;
      logic [31:0] r;
      idx  = '0;
      prev = '0;
      for (int i = 0; i <= count; i++) begin
         wait_pix_high();
         if (i < count) begin
            if (sequential) begin
               idx = 5'(i);
            end else begin
               take_bits(5, r);
               idx = r[4:0];
            end
            pix_index_i = idx;
         end
         tick();
         if (i > 0) begin
            check_value(test, 32'(expected_rgb(prev, milli_i)), 32'(rgb_o));
         end
         prev = idx;
      end
   endtask

   task automatic fill_centipede();
      logic [31:0] a;
      logic [31:0] d;
      for (int i = 0; i < 16; i++) begin
         // top address bit is random and must be ignored
         take_bits(1, a);
         take_bits(8, d);
         host_write({a[0], 4'(i)}, d[7:0]);
      end
      tick();
   endtask

   initial begin
      logic [31:0] d;
      hs_set      = 1'b1;
      milli_i     = 1'b0;
      cram_wr_i   = 1'b0;
      cram_addr_i = '0;
      cram_data_i = '0;
      pix_index_i = '0;
      lfsr_state  = 32'h1217;

      repeat (10) begin
         tick();
         check_reset_state("reset_hold");
      end
      hs_set = 1'b0;
      #20;
      check_reset_state("reset_release");

      measure_period(1'b0, line_total, sync_high, blank_high);
      check_value("h_period", 32'd768, 32'(line_total));
      check_value("hsync_width", 32'd64, 32'(sync_high));
      check_value("hblank_width", 32'd256, 32'(blank_high));

      measure_period(1'b1, line_total, sync_high, blank_high);
      check_value("v_period", 32'(256 * 768), 32'(line_total));
      check_value("vsync_width", 32'(4 * 768), 32'(sync_high));
      check_value("vblank_width", 32'(16 * 768), 32'(blank_high));

      // centipede palette
      fill_centipede();
      run_pixels("centi_palette", 200, 1'b0);

      // millipede palette over all 32 entries
      milli_i = 1'b1;
      for (int i = 0; i < 32; i++) begin
         take_bits(8, d);
         host_write(5'(i), d[7:0]);
      end
      tick();
      run_pixels("milli_palette", 200, 1'b0);

      // nibble written in centipede mode, read back as millipede
      milli_i = 1'b0;
      tick();
      fill_centipede();
      milli_i = 1'b1;
      tick();
      run_pixels("nibble_dup", 16, 1'b1);

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== centi_video.f ====
rtl/centi_video_pkg.sv
rtl/video_timing_if.sv
rtl/video_timing.sv
rtl/color_ram.sv
rtl/palette_encoder.sv
rtl/centi_video_top.sv
sim/centi_video_props.sv
sim/centi_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module centi_video_tb \
   -f centi_video.f \
   --Mdir obj_dir \
   -o centi_video_sim

# the simulator exits non-zero on any failure
./obj_dir/centi_video_sim
